// ==== common/rx_data_pkg.sv ====
package rx_data_pkg;

    ////////////////////////////////////////
    // datapath dimensions
    ////////////////////////////////////////

    // interleaved lanes in one word
    localparam int NTI = 16;

    // adc code width, two's complement
    localparam int NADC = 8;

    // phase interpolator code width
    localparam int NPI = 9;

    // number of pi outputs
    localparam int NOUT = 4;

    // prbs order
    localparam int NPRBS = 7;

    // width of the pi max-select field
    localparam int NMAXSEL = 5;

    ////////////////////////////////////////
    // datapath words
    ////////////////////////////////////////

    // one signed code per lane, lane 0 in the low bits
    typedef struct packed {
        logic signed [NTI-1:0][NADC-1:0] code;
    } adc_word_t;

    // lane 0 is the earliest bit in time
    typedef logic [NTI-1:0] bit_word_t;

    // pi control codes toward the analog front end
    typedef struct packed {
        logic [NOUT-1:0][NPI-1:0] code;
    } pi_codes_t;

endpackage

// ==== common/rx_reg_pkg.sv ====
package rx_reg_pkg;

    ////////////////////////////////////////
    // apb bus
    ////////////////////////////////////////

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    ////////////////////////////////////////
    // register map
    ////////////////////////////////////////

    localparam logic [7:0] ADDR_CTRL   = 8'h00;
    localparam logic [7:0] ADDR_THRESH = 8'h04;
    localparam logic [7:0] ADDR_SEED   = 8'h08;
    localparam logic [7:0] ADDR_INJ    = 8'h0C;
    // one word per pi output from here
    localparam logic [7:0] ADDR_PI0    = 8'h10;
    localparam logic [7:0] ADDR_ERR    = 8'h20;
    localparam logic [7:0] ADDR_TOTAL  = 8'h24;

    // clear is a one-cycle pulse
    typedef struct packed {
        logic clear;
        logic src_bist;
        logic gen_en;
        logic chk_en;
    } ctrl_t;

    localparam int PI_CFG_W = 16;

    typedef struct packed {
        logic                                en_bypass;
        logic [PI_CFG_W-2-rx_data_pkg::NMAXSEL-rx_data_pkg::NPI:0] rsvd;
        logic [rx_data_pkg::NMAXSEL-1:0]     max_sel;
        logic [rx_data_pkg::NPI-1:0]         code;
    } pi_scaled_t;

    typedef struct packed {
        logic                                en_bypass;
        logic [PI_CFG_W-2-rx_data_pkg::NPI:0] rsvd;
        logic [rx_data_pkg::NPI-1:0]         code;
    } pi_bypass_t;

    // same word, read either as a scaled code or a bypass code
    typedef union packed {
        pi_scaled_t scaled;
        pi_bypass_t bypass;
    } pi_cfg_u;

endpackage

// ==== design/apb_regs.sv ====
`timescale 1ns/10ps

module apb_regs (
    input  logic                                        clk_adc,
    input  logic                                        reset_i,
    input  rx_reg_pkg::apb_req_t                        apb_i,
    input  logic [31:0]                                 err_cnt_i,
    input  logic [31:0]                                 total_cnt_i,
    output rx_reg_pkg::apb_rsp_t                        apb_o,
    output rx_reg_pkg::ctrl_t                           ctrl_o,
    output logic signed [rx_data_pkg::NADC-1:0]         thresh_o,
    output logic [rx_data_pkg::NPRBS-1:0]               seed_o,
    output logic                                        seed_load_o,
    output logic                                        inj_err_o,
    output rx_reg_pkg::pi_cfg_u [rx_data_pkg::NOUT-1:0] pi_cfg_o
);
    import rx_data_pkg::*;
    import rx_reg_pkg::*;

    localparam int PI_IDX_W = $clog2(NOUT);

    logic                access;
    logic                wr_en;
    logic                mapped;
    logic                read_only;
    logic                pi_hit;
    logic [7:0]          pi_off;
    logic [PI_IDX_W-1:0] pi_idx;
    logic [31:0]         rdata;

    assign access = apb_i.psel & apb_i.penable;
    assign wr_en  = access & apb_i.pwrite & mapped & ~read_only;

    // pi words are word aligned from ADDR_PI0
    assign pi_off = apb_i.paddr - ADDR_PI0;
    assign pi_hit = (apb_i.paddr >= ADDR_PI0) && (pi_off < 8'(4 * NOUT)) &&
                    (apb_i.paddr[1:0] == 2'b00);
    assign pi_idx = pi_off[PI_IDX_W+1:2];

    ////////////////////////////////////////
    // read path and decode
    ////////////////////////////////////////

    always_comb begin
        rdata     = '0;
        mapped    = 1'b1;
        read_only = 1'b0;
        if (pi_hit) begin
            rdata = 32'(pi_cfg_o[pi_idx]);
        end else begin
            case (apb_i.paddr)
                ADDR_CTRL:   rdata = 32'(ctrl_o);
                ADDR_THRESH: rdata = 32'($unsigned(thresh_o));
                ADDR_SEED:   rdata = 32'(seed_o);
                // write-only trigger
                ADDR_INJ:    rdata = '0;
                ADDR_ERR: begin
                    rdata     = err_cnt_i;
                    read_only = 1'b1;
                end
                ADDR_TOTAL: begin
                    rdata     = total_cnt_i;
                    read_only = 1'b1;
                end
                default:     mapped = 1'b0;
            endcase
        end
    end

    assign apb_o = '{prdata: rdata, pready: access,
                     pslverr: access & (~mapped | (apb_i.pwrite & read_only))};

    ////////////////////////////////////////
    // write path
    ////////////////////////////////////////

    always_ff @(posedge clk_adc) begin
        if (reset_i) begin
            ctrl_o      <= '0;
            thresh_o    <= '0;
            seed_o      <= '0;
            seed_load_o <= 1'b0;
            inj_err_o   <= 1'b0;
            pi_cfg_o    <= '0;
        end else begin
            // strobes drop after one cycle
            ctrl_o.clear <= 1'b0;
            seed_load_o  <= 1'b0;
            inj_err_o    <= 1'b0;
            if (wr_en && pi_hit) begin
                pi_cfg_o[pi_idx] <= apb_i.pwdata[$bits(pi_cfg_u)-1:0];
            end else if (wr_en) begin
                case (apb_i.paddr)
                    ADDR_CTRL:   ctrl_o   <= apb_i.pwdata[$bits(ctrl_t)-1:0];
                    ADDR_THRESH: thresh_o <= apb_i.pwdata[NADC-1:0];
                    ADDR_SEED: begin
                        seed_o      <= apb_i.pwdata[NPRBS-1:0];
                        seed_load_o <= 1'b1;
                    end
                    ADDR_INJ:    inj_err_o <= 1'b1;
                    default:     ;
                endcase
            end
        end
    end

    // access phase only ever follows a setup phase
    a_apb_setup: assert property (@(posedge clk_adc) disable iff (reset_i)
        apb_i.penable |-> $past(apb_i.psel && !apb_i.penable));

endmodule

// ==== design/adc_slicer.sv ====
`timescale 1ns/10ps

module adc_slicer #(
    parameter int N_LANES = rx_data_pkg::NTI
) (
    input  logic                                clk_adc,
    input  logic                                reset_i,
    input  rx_data_pkg::adc_word_t              adc_i,
    input  logic signed [rx_data_pkg::NADC-1:0] thresh_i,
    output rx_data_pkg::bit_word_t              bits_o
);
    import rx_data_pkg::*;

    bit_word_t slice_d;

    // strictly above threshold gives a one
    always_comb begin
        slice_d = '0;
        for (int i = 0; i < N_LANES; i++) begin
            slice_d[i] = $signed(adc_i.code[i]) > thresh_i;
        end
    end

    always_ff @(posedge clk_adc) begin
        if (reset_i) begin
            bits_o <= '0;
        end else begin
            bits_o <= slice_d;
        end
    end

endmodule

// ==== design/pi_ctl_scale.sv ====
`timescale 1ns/10ps

module pi_ctl_scale (
    input  logic                                        clk_adc,
    input  logic                                        reset_i,
    input  rx_reg_pkg::pi_cfg_u [rx_data_pkg::NOUT-1:0] pi_cfg_i,
    output rx_data_pkg::pi_codes_t                      pi_ctl_o
);
    import rx_data_pkg::*;

    logic [NOUT-1:0][NPI-1:0]   scale_val;
    logic [NOUT-1:0][2*NPI-1:0] scaled;
    pi_codes_t                  pi_d;

    always_comb begin
        for (int j = 0; j < NOUT; j++) begin
            // (max_sel + 1) * 16 - 1, tops out at full scale
            scale_val[j] = NPI'(((NPI'(pi_cfg_i[j].scaled.max_sel) + 1) << 4) - 1);
            scaled[j]    = pi_cfg_i[j].scaled.code * scale_val[j];
            if (pi_cfg_i[j].bypass.en_bypass) begin
                pi_d.code[j] = pi_cfg_i[j].bypass.code;
            end else begin
                pi_d.code[j] = scaled[j][2*NPI-1:NPI];
            end
        end
    end

    always_ff @(posedge clk_adc) begin
        if (reset_i) begin
            pi_ctl_o <= '0;
        end else begin
            pi_ctl_o <= pi_d;
        end
    end

    // scaling only ever shrinks the code
    for (genvar j = 0; j < NOUT; j++) begin : g_scale_chk
        a_scale_le: assert property (@(posedge clk_adc) disable iff (reset_i)
            !pi_cfg_i[j].bypass.en_bypass |=>
                pi_ctl_o.code[j] <= $past(pi_cfg_i[j].scaled.code));
    end

endmodule

// ==== prbs/prbs_gen.sv ====
`timescale 1ns/10ps

module prbs_gen #(
    parameter int N_LANES = rx_data_pkg::NTI
) (
    input  logic                           clk_adc,
    input  logic                           reset_i,
    input  logic                           gen_en_i,
    input  logic [rx_data_pkg::NPRBS-1:0]  seed_i,
    input  logic                           seed_load_i,
    input  logic                           inj_err_i,
    output rx_data_pkg::bit_word_t         bits_o
);
    import rx_data_pkg::*;

    // last NPRBS lanes of the word hold the state, tail[0] oldest
    logic [NPRBS-1:0] tail;
    bit_word_t        next_word;
    bit_word_t        seed_word;
    logic             inj_pend_q;
    logic             flip;

    always_comb begin
        next_word = '0;
        tail      = bits_o[N_LANES-1 -: NPRBS];
        for (int i = 0; i < N_LANES; i++) begin
            next_word[i] = tail[0] ^ tail[1];
            tail         = {next_word[i], tail[NPRBS-1:1]};
        end
    end

    // zero seed would lock the lfsr
    always_comb begin
        seed_word                        = '0;
        seed_word[N_LANES-1 -: NPRBS]    = (seed_i == '0) ? '1 : seed_i;
    end

    // an injection waits for the next generated word
    assign flip = inj_err_i | inj_pend_q;

    always_ff @(posedge clk_adc) begin
        if (reset_i) begin
            bits_o     <= '1;
            inj_pend_q <= 1'b0;
        end else begin
            if (seed_load_i) begin
                bits_o <= seed_word;
            end else if (gen_en_i) begin
                bits_o <= next_word ^ bit_word_t'(flip);
            end
            inj_pend_q <= flip & ~(gen_en_i & ~seed_load_i);
        end
    end

endmodule

// ==== prbs/prbs_check.sv ====
`timescale 1ns/10ps

module prbs_check #(
    parameter int N_LANES = rx_data_pkg::NTI
) (
    input  logic                   clk_adc,
    input  logic                   reset_i,
    input  rx_reg_pkg::ctrl_t      ctrl_i,
    input  rx_data_pkg::bit_word_t adc_bits_i,
    input  rx_data_pkg::bit_word_t bist_bits_i,
    output logic [31:0]            err_cnt_o,
    output logic [31:0]            total_cnt_o
);
    import rx_data_pkg::*;

    localparam int ERR_W = $clog2(N_LANES + 1);

    bit_word_t        rx_word;
    logic [NPRBS-1:0] hist_q;
    logic [NPRBS-1:0] hist_d;
    logic [ERR_W-1:0] err_sum;
    logic             primed_q;

    assign rx_word = ctrl_i.src_bist ? bist_bits_i : adc_bits_i;

    ////////////////////////////////////////
    // self-synchronizing prediction
    ////////////////////////////////////////

    // hist_d[0] holds the oldest bit
    // predicted bit is b[n-7] ^ b[n-6]
    always_comb begin
        hist_d  = hist_q;
        err_sum = '0;
        for (int i = 0; i < N_LANES; i++) begin
            err_sum = err_sum + ERR_W'(hist_d[0] ^ hist_d[1] ^ rx_word[i]);
            hist_d  = {rx_word[i], hist_d[NPRBS-1:1]};
        end
    end

    always_ff @(posedge clk_adc) begin
        if (reset_i) begin
            hist_q <= '0;
        end else if (ctrl_i.chk_en) begin
            hist_q <= hist_d;
        end
    end

    // first word after enable only seeds the history
    always_ff @(posedge clk_adc) begin
        if (reset_i) begin
            primed_q    <= 1'b0;
            err_cnt_o   <= '0;
            total_cnt_o <= '0;
        end else begin
            primed_q <= ctrl_i.chk_en;
            if (ctrl_i.clear) begin
                err_cnt_o   <= '0;
                total_cnt_o <= '0;
            end else if (ctrl_i.chk_en && primed_q) begin
                err_cnt_o   <= err_cnt_o + 32'(err_sum);
                total_cnt_o <= total_cnt_o + 32'(N_LANES);
            end
        end
    end

    // counters only drop on a clear
    a_cnt_mono: assert property (@(posedge clk_adc) disable iff (reset_i)
        !ctrl_i.clear |=> (err_cnt_o >= $past(err_cnt_o)) &&
                          (total_cnt_o >= $past(total_cnt_o)));

endmodule

// ==== design/rx_dcore.sv ====
`timescale 1ns/10ps

module rx_dcore (
    input  logic                   clk_adc,
    input  logic                   reset_i,
    input  rx_data_pkg::adc_word_t adc_i,
    input  rx_reg_pkg::apb_req_t   apb_i,
    output rx_reg_pkg::apb_rsp_t   apb_o,
    output rx_data_pkg::pi_codes_t pi_ctl_o
);
    import rx_data_pkg::*;
    import rx_reg_pkg::*;

    localparam int N_LANES = NTI;

    ctrl_t                  ctrl;
    logic signed [NADC-1:0] thresh;
    logic [NPRBS-1:0]       seed;
    logic                   seed_load;
    logic                   inj_err;
    pi_cfg_u [NOUT-1:0]     pi_cfg;
    logic [31:0]            err_cnt;
    logic [31:0]            total_cnt;
    bit_word_t              adc_bits;
    bit_word_t              bist_bits;

    ////////////////////////////////////////
    // configuration
    ////////////////////////////////////////

    apb_regs u_regs (
        .clk_adc     (clk_adc),
        .reset_i     (reset_i),
        .apb_i       (apb_i),
        .err_cnt_i   (err_cnt),
        .total_cnt_i (total_cnt),
        .apb_o       (apb_o),
        .ctrl_o      (ctrl),
        .thresh_o    (thresh),
        .seed_o      (seed),
        .seed_load_o (seed_load),
        .inj_err_o   (inj_err),
        .pi_cfg_o    (pi_cfg)
    );

    ////////////////////////////////////////
    // data and test path
    ////////////////////////////////////////

    adc_slicer #(.N_LANES(N_LANES)) u_slicer (
        .clk_adc  (clk_adc),
        .reset_i  (reset_i),
        .adc_i    (adc_i),
        .thresh_i (thresh),
        .bits_o   (adc_bits)
    );

    prbs_gen #(.N_LANES(N_LANES)) u_gen (
        .clk_adc     (clk_adc),
        .reset_i     (reset_i),
        .gen_en_i    (ctrl.gen_en),
        .seed_i      (seed),
        .seed_load_i (seed_load),
        .inj_err_i   (inj_err),
        .bits_o      (bist_bits)
    );

    prbs_check #(.N_LANES(N_LANES)) u_check (
        .clk_adc     (clk_adc),
        .reset_i     (reset_i),
        .ctrl_i      (ctrl),
        .adc_bits_i  (adc_bits),
        .bist_bits_i (bist_bits),
        .err_cnt_o   (err_cnt),
        .total_cnt_o (total_cnt)
    );

    // pi codes come from the registers only
    pi_ctl_scale u_pi (
        .clk_adc  (clk_adc),
        .reset_i  (reset_i),
        .pi_cfg_i (pi_cfg),
        .pi_ctl_o (pi_ctl_o)
    );

endmodule

// ==== verification/tb_clock.sv ====
`timescale 1ns/10ps

module tb_clock (
    output logic clk_o,
    output logic reset_o
);
    localparam int HALF_NS = 20;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_NS) clk_o = ~clk_o;
    end

    // reset held for two rising edges
    initial begin
        reset_o = 1'b1;
        repeat (2) @(posedge clk_o);
        reset_o <= 1'b0;
    end

endmodule

// ==== verification/tb_rx_dcore.sv ====
`timescale 1ns/10ps

module tb_rx_dcore;
    import rx_data_pkg::*;
    import rx_reg_pkg::*;

    localparam int CLK_NS      = 40;
    localparam int APB_CYC     = 3;
    localparam int N_XFER      = 48;
    localparam int RUN_MAX     = 84;
    localparam int SLICE_WORDS = 56;
    // transfers, bist runs, injection gaps and the slicer stream
    localparam int TEST_CYCLES = N_XFER * APB_CYC + RUN_MAX + 64 + SLICE_WORDS + 16;

    logic        clk_adc;
    logic        reset_i;
    adc_word_t   adc_i;
    apb_req_t    apb_i;
    apb_rsp_t    apb_o;
    pi_codes_t   pi_ctl_o;

    logic [31:0] rng_state = 32'h7737_f7fd;
    string       name_q[$];
    logic [31:0] got_q[$];
    logic [31:0] exp_q[$];
    logic [15:0] tx_words[SLICE_WORDS];
    int          slice_thresh;

    tb_clock u_clock (
        .clk_o   (clk_adc),
        .reset_o (reset_i)
    );

    rx_dcore u_dut (
        .clk_adc  (clk_adc),
        .reset_i  (reset_i),
        .adc_i    (adc_i),
        .apb_i    (apb_i),
        .apb_o    (apb_o),
        .pi_ctl_o (pi_ctl_o)
    );

    ////////////////////////////////////////
    // reference models
    ////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] draw_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // serial stream, s[n] = s[n-7] ^ s[n-6], last7[0] oldest
    function automatic logic [15:0] prbs_next(input logic [6:0] last7);
        logic [22:0] s;
        s      = '0;
        s[6:0] = last7;
        for (int n = 7; n < 23; n++) begin
            s[n] = s[n-7] ^ s[n-6];
        end
        return s[22:7];
    endfunction

    // mismatches of one received word against the self-sync prediction
    function automatic int count_errors(input logic [6:0] last7, input logic [15:0] word);
        logic [22:0] s;
        int          errs;
        s    = {word, last7};
        errs = 0;
        for (int n = 7; n < 23; n++) begin
            if (s[n] != (s[n-7] ^ s[n-6])) errs++;
        end
        return errs;
    endfunction

    function automatic logic [8:0] pi_ref(input logic [15:0] cfg);
        int scale;
        int prod;
        if (cfg[15]) return cfg[8:0];
        scale = (int'(cfg[13:9]) + 1) * 16 - 1;
        prod  = int'(cfg[8:0]) * scale;
        return 9'(prod >> NPI);
    endfunction

    // adc code strictly above or at/below the threshold
    function automatic logic [7:0] slice_code(input logic b, input int th);
        int code;
        if (b) code = th + 1 + int'(draw_random() % (127 - th));
        else   code = th - int'(draw_random() % (th + 129));
        return 8'(code);
    endfunction

    ////////////////////////////////////////
    // checking
    ////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("FAIL: see errors above");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic post_check(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        name_q.push_back(name);
        got_q.push_back(got);
        exp_q.push_back(exp);
    endtask

    initial begin : compare
        forever begin
            @(posedge clk_adc);
            while (name_q.size() != 0) begin
                check_value(name_q.pop_front(), got_q.pop_front(), exp_q.pop_front());
            end
        end
    end

    initial begin : watchdog
        #(TEST_CYCLES * CLK_NS * 4);
        $display("timeout: the tests did not finish in time");
        $display("FAIL: see errors above");
        $fatal(1, "watchdog expired");
    end

    ////////////////////////////////////////
    // bus and stream drivers
    ////////////////////////////////////////

    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic slverr);
        @(posedge clk_adc);
        apb_i <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(posedge clk_adc);
        apb_i.penable <= 1'b1;
        // access cycle, response is settled by now
        @(negedge clk_adc);
        post_check("apb_o.pready", 32'(apb_o.pready), 32'h1);
        rdata  = apb_o.prdata;
        slverr = apb_o.pslverr;
        @(posedge clk_adc);
        apb_i <= '0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b1, addr, wdata, rd, err);
        post_check("apb_o.pslverr", 32'(err), 32'h0);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] rdata);
        logic err;
        apb_xfer(1'b0, addr, '0, rdata, err);
        post_check("apb_o.pslverr", 32'(err), 32'h0);
    endtask

    task automatic drive_adc_stream();
        adc_word_t aw;
        for (int k = 0; k < SLICE_WORDS; k++) begin
            @(posedge clk_adc);
            for (int i = 0; i < NTI; i++) begin
                aw.code[i] = slice_code(tx_words[k][i], slice_thresh);
            end
            adc_i <= aw;
        end
    endtask

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    initial begin : stimulus
        logic [31:0] rd;
        logic [31:0] r;
        logic        err;
        logic [6:0]  hist7;
        logic [15:0] cfg;
        int          exp_err;

        apb_i = '0;
        adc_i = '0;
        @(posedge clk_adc);
        while (reset_i) @(posedge clk_adc);

        // reset values and register access
        apb_read(ADDR_CTRL, rd);
        post_check("ctrl", rd, 32'h0);
        apb_read(ADDR_ERR, rd);
        post_check("err_cnt", rd, 32'h0);
        apb_read(ADDR_TOTAL, rd);
        post_check("total_cnt", rd, 32'h0);
        r = draw_random();
        apb_write(ADDR_THRESH, {24'h0, r[7:0]});
        apb_read(ADDR_THRESH, rd);
        post_check("thresh", rd, {24'h0, r[7:0]});
        apb_xfer(1'b1, ADDR_ERR, 32'h1, rd, err);
        post_check("pslverr on ADDR_ERR write", 32'(err), 32'h1);
        apb_xfer(1'b1, 8'h40, 32'h1, rd, err);
        post_check("pslverr on 0x40 write", 32'(err), 32'h1);

        // bist loop with a clean stream
        apb_write(ADDR_SEED, draw_random() & 32'h7f);
        apb_write(ADDR_CTRL, 32'h7);
        repeat (20 + int'(draw_random() % 64)) @(posedge clk_adc);
        apb_write(ADDR_CTRL, 32'h4);
        apb_read(ADDR_ERR, rd);
        post_check("err_cnt", rd, 32'h0);
        apb_read(ADDR_TOTAL, rd);
        post_check("total_cnt % 16", rd % 16, 32'h0);
        post_check("total_cnt != 0", 32'(rd != 0), 32'h1);
        apb_write(ADDR_CTRL, 32'hc);

        // three spaced injections, three errors per flipped bit
        apb_write(ADDR_CTRL, 32'h7);
        repeat (10) @(posedge clk_adc);
        repeat (3) begin
            apb_write(ADDR_INJ, 32'h1);
            repeat (12) @(posedge clk_adc);
        end
        apb_write(ADDR_CTRL, 32'h4);
        apb_read(ADDR_ERR, rd);
        post_check("err_cnt", rd, 32'd9);
        apb_write(ADDR_CTRL, 32'h8);
        apb_read(ADDR_ERR, rd);
        post_check("err_cnt after clear", rd, 32'h0);
        apb_read(ADDR_TOTAL, rd);
        post_check("total_cnt after clear", rd, 32'h0);

        // slicer path fed by a reference stream with two flips
        slice_thresh = int'(draw_random() % 200) - 100;
        apb_write(ADDR_THRESH, 32'(slice_thresh) & 32'hff);
        r     = draw_random();
        hist7 = (r[6:0] == '0) ? 7'h7f : r[6:0];
        for (int k = 0; k < SLICE_WORDS; k++) begin
            tx_words[k] = prbs_next(hist7);
            hist7       = tx_words[k][15:9];
        end
        tx_words[14][3]  = ~tx_words[14][3];
        tx_words[28][12] = ~tx_words[28][12];
        exp_err = 0;
        for (int k = 1; k < SLICE_WORDS; k++) begin
            exp_err += count_errors(tx_words[k-1][15:9], tx_words[k]);
        end
        fork
            drive_adc_stream();
            begin
                apb_write(ADDR_CTRL, 32'h1);
                repeat (32) @(posedge clk_adc);
                apb_write(ADDR_CTRL, 32'h0);
            end
        join
        apb_read(ADDR_ERR, rd);
        post_check("err_cnt slicer path", rd, 32'(exp_err));
        apb_write(ADDR_CTRL, 32'h8);

        // pi codes, scaled and bypassed
        for (int rnd = 0; rnd < 3; rnd++) begin
            for (int j = 0; j < NOUT; j++) begin
                r   = draw_random();
                cfg = {(rnd == 0) ? j[0] : r[31], 1'b0, r[13:9], r[8:0]};
                apb_write(ADDR_PI0 + 8'(4 * j), {16'h0, cfg});
                @(posedge clk_adc);
                @(negedge clk_adc);
                post_check("pi_ctl_o", 32'(pi_ctl_o.code[j]), 32'(pi_ref(cfg)));
            end
        end

        while (name_q.size() != 0) @(posedge clk_adc);
        @(posedge clk_adc);
        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== sources.f ====
common/rx_data_pkg.sv
common/rx_reg_pkg.sv
design/apb_regs.sv
design/adc_slicer.sv
design/pi_ctl_scale.sv
prbs/prbs_gen.sv
prbs/prbs_check.sv
design/rx_dcore.sv
verification/tb_clock.sv
verification/tb_rx_dcore.sv
